/* fir_dsp_pkg.sv */
`default_nettype none

package fir_dsp_pkg;

    // Sample and coefficient widths.
    localparam int DATA_W  = 16;
    localparam int COEFF_W = 16;

    // Full-precision product of one tap.
    localparam int PROD_W  = DATA_W + COEFF_W;

    // Six guard bits cover the sum of up to 64 products.
    localparam int ACC_W   = PROD_W + 6;

    // Largest value the output can carry.
    localparam logic [DATA_W-1:0] SAMPLE_MAX = '1;

    typedef logic [DATA_W-1:0]  sample_t;   // Unsigned input and output sample.
    typedef logic [COEFF_W-1:0] coeff_t;    // Unsigned tap coefficient.
    typedef logic [PROD_W-1:0]  product_t;  // Sample times coefficient.
    typedef logic [ACC_W-1:0]   acc_t;      // Accumulated tap sum.

endpackage

`default_nettype wire

/* fir_cfg_pkg.sv */
`default_nettype none

package fir_cfg_pkg;

    // Six address bits reach up to 64 taps.
    localparam int CADDR_W = 6;

    // Host command on the configuration port.
    typedef enum logic [1:0] {
        CFG_NOP   = 2'd0,  // Idle cycle.
        CFG_WRITE = 2'd1,  // Store cfg_data at cfg_addr.
        CFG_CLEAR = 2'd2   // Zero every coefficient.
    } cfg_cmd_e;

endpackage

`default_nettype wire

/* fir_coeff_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_coeff_bank #(
    parameter int NUM_TAPS = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  fir_cfg_pkg::cfg_cmd_e           cfg_cmd,
    input  logic [fir_cfg_pkg::CADDR_W-1:0] cfg_addr,
    input  fir_dsp_pkg::coeff_t             cfg_data,
    output fir_dsp_pkg::coeff_t             coeffs [NUM_TAPS]
);

    import fir_dsp_pkg::*;
    import fir_cfg_pkg::*;

    // One register per tap. Addresses at or above NUM_TAPS match no entry.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coeffs[i] <= '0;
            end
        end else begin
            case (cfg_cmd)
                CFG_CLEAR: begin
                    for (int i = 0; i < NUM_TAPS; i++) begin
                        coeffs[i] <= '0;
                    end
                end
                CFG_WRITE: begin
                    for (int i = 0; i < NUM_TAPS; i++) begin
                        if (cfg_addr == CADDR_W'(i)) begin
                            coeffs[i] <= cfg_data;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // The host must only issue defined commands.
    a_cmd_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_cmd inside {CFG_NOP, CFG_WRITE, CFG_CLEAR}
    );

endmodule

`default_nettype wire

/* fir_delay_line.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_delay_line #(
    parameter int NUM_TAPS = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_valid,
    input  fir_dsp_pkg::sample_t sample_in,
    output fir_dsp_pkg::sample_t taps [NUM_TAPS],
    output logic                 tap_valid
);

    import fir_dsp_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                taps[i] <= '0;
            end
            tap_valid <= 1'b0;
        end else begin
            tap_valid <= sample_valid;  // Taps are fresh one cycle after the strobe.
            if (sample_valid) begin
                taps[0] <= sample_in;   // Tap 0 holds the newest sample.
                for (int i = 1; i < NUM_TAPS; i++) begin
                    taps[i] <= taps[i-1];
                end
            end
        end
    end

    // Without a strobe every tap must hold its sample.
    for (genvar i = 0; i < NUM_TAPS; i++) begin : g_hold
        a_hold_tap: assert property (
            @(posedge clk) disable iff (!rst_n)
            !sample_valid |=> $stable(taps[i])
        );
    end

endmodule

`default_nettype wire

/* fir_mac_tree.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_mac_tree #(
    parameter int NUM_TAPS  = 32,
    parameter int OUT_SHIFT = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fir_dsp_pkg::sample_t taps [NUM_TAPS],
    input  fir_dsp_pkg::coeff_t  coeffs [NUM_TAPS],
    input  logic                 tap_valid,
    output logic                 out_valid,
    output fir_dsp_pkg::sample_t data_out,
    output logic                 out_sat
);

    import fir_dsp_pkg::*;

    localparam int GRP_SIZE = 8;
    localparam int NUM_GRP  = (NUM_TAPS + GRP_SIZE - 1) / GRP_SIZE;
    localparam int PAD_TAPS = NUM_GRP * GRP_SIZE;

    product_t prod_q   [NUM_TAPS];
    product_t prod_pad [PAD_TAPS];
    acc_t     psum_d   [NUM_GRP];
    acc_t     psum_q   [NUM_GRP];
    acc_t     total;
    acc_t     shifted;
    logic     over;
    logic     prod_valid;
    logic     psum_valid;

    // Stage 1 registers one product per tap.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod_q[i] <= product_t'(taps[i]) * product_t'(coeffs[i]);
        end
    end

    // Fill the last group with zero products.
    always_comb begin
        for (int i = 0; i < PAD_TAPS; i++) begin
            prod_pad[i] = '0;
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod_pad[i] = prod_q[i];
        end
    end

    // Stage 2 reduces each group of eight products.
    always_comb begin
        for (int g = 0; g < NUM_GRP; g++) begin
            psum_d[g] = '0;
            for (int k = 0; k < GRP_SIZE; k++) begin
                psum_d[g] = psum_d[g] + acc_t'(prod_pad[g*GRP_SIZE + k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int g = 0; g < NUM_GRP; g++) begin
            psum_q[g] <= psum_d[g];
        end
    end

    // Stage 3 adds the partial sums, scales and clips.
    always_comb begin
        total = '0;
        for (int g = 0; g < NUM_GRP; g++) begin
            total = total + psum_q[g];
        end
        shifted = total >> OUT_SHIFT;
        over    = |shifted[ACC_W-1:DATA_W];  // Anything above 16 bits clips.
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            psum_valid <= 1'b0;
            out_valid  <= 1'b0;
            out_sat    <= 1'b0;
            data_out   <= '0;
        end else begin
            prod_valid <= tap_valid;
            psum_valid <= prod_valid;
            out_valid  <= psum_valid;
            out_sat    <= psum_valid & over;
            if (psum_valid) begin
                data_out <= over ? SAMPLE_MAX : shifted[DATA_W-1:0];
            end
        end
    end

    // The delay line and three stages leave no result for four cycles.
    a_no_early_valid: assert property (
        @(posedge clk) $rose(rst_n) |-> !out_valid [*4]
    );

    // A clipped result is a valid result at full scale.
    a_sat_with_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_sat |-> (out_valid && data_out == SAMPLE_MAX)
    );

endmodule

`default_nettype wire

/* fir_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_top #(
    parameter int NUM_TAPS  = 32,
    parameter int OUT_SHIFT = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sample_valid,
    input  fir_dsp_pkg::sample_t            sample_in,
    input  fir_cfg_pkg::cfg_cmd_e           cfg_cmd,
    input  logic [fir_cfg_pkg::CADDR_W-1:0] cfg_addr,
    input  fir_dsp_pkg::coeff_t             cfg_data,
    output logic                            out_valid,
    output fir_dsp_pkg::sample_t            data_out,
    output logic                            out_sat
);

    import fir_dsp_pkg::*;

    coeff_t  coeffs [NUM_TAPS];
    sample_t taps   [NUM_TAPS];
    logic    tap_valid;

    fir_coeff_bank #(
        .NUM_TAPS (NUM_TAPS)
    ) u_coeff_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_cmd  (cfg_cmd),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .coeffs   (coeffs)
    );

    fir_delay_line #(
        .NUM_TAPS (NUM_TAPS)
    ) u_delay_line (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .taps         (taps),
        .tap_valid    (tap_valid)
    );

    // Three more cycles after the delay line.
    fir_mac_tree #(
        .NUM_TAPS  (NUM_TAPS),
        .OUT_SHIFT (OUT_SHIFT)
    ) u_mac_tree (
        .clk       (clk),
        .rst_n     (rst_n),
        .taps      (taps),
        .coeffs    (coeffs),
        .tap_valid (tap_valid),
        .out_valid (out_valid),
        .data_out  (data_out),
        .out_sat   (out_sat)
    );

endmodule

`default_nettype wire

/* tb_fir_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fir_top;

    import fir_dsp_pkg::*;
    import fir_cfg_pkg::*;

    localparam int NUM_TAPS  = 32;
    localparam int OUT_SHIFT = 16;

    // Stimulus length of each test, drain included.
    localparam int STIM_CYCLES = 14                      // Reset and idle.
                               + (NUM_TAPS + 40 + 10)    // Impulse.
                               + (NUM_TAPS + 200 + 10)   // Random stream.
                               + (NUM_TAPS + 40 + 10)    // Saturation.
                               + (1 + 40 + 10)           // Clear.
                               + (2 + 40 + 10)           // Rewrite.
                               + (NUM_TAPS + 400 + 10);  // Gaps, up to 4 cycles per sample.
    localparam int MAX_CYCLES  = STIM_CYCLES + 200;

    typedef struct packed {
        int          cyc;   // Cycle in which the sample was driven.
        logic        sat;
        logic [15:0] data;
    } exp_t;

    logic                 clk;
    logic                 rst_n;
    logic                 sample_valid;
    sample_t              sample_in;
    cfg_cmd_e             cfg_cmd;
    logic [CADDR_W-1:0]   cfg_addr;
    coeff_t               cfg_data;
    logic                 out_valid;
    sample_t              data_out;
    logic                 out_sat;

    int          cyc    = 0;
    int          errors = 0;
    int          checks = 0;
    string       test_name = "reset";
    logic [15:0] lfsr_state = 16'd87;
    sample_t     ref_hist [NUM_TAPS];
    coeff_t      ref_coef [NUM_TAPS];
    exp_t        exp_q [$];
    sample_t     last_data;
    logic        last_sat;

    fir_top #(
        .NUM_TAPS  (NUM_TAPS),
        .OUT_SHIFT (OUT_SHIFT)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .cfg_cmd      (cfg_cmd),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .out_valid    (out_valid),
        .data_out     (data_out),
        .out_sat      (out_sat)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Galois LFSR, one step per random bit.
    function automatic logic lfsr_step();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[14:0], lfsr_step()};
        end
        return r;
    endfunction

    // Direct-form FIR on its own history: {saturated, value}.
    function automatic logic [16:0] ref_filter(input logic [15:0] s);
        logic [63:0] acc;
        logic [63:0] shifted;
        acc = '0;
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
            ref_hist[i] = ref_hist[i-1];
        end
        ref_hist[0] = s;
        for (int i = 0; i < NUM_TAPS; i++) begin
            acc = acc + 64'(ref_hist[i]) * 64'(ref_coef[i]);
        end
        shifted = acc >> OUT_SHIFT;
        if (shifted > 64'd65535) begin
            return {1'b1, 16'hFFFF};
        end
        return {1'b0, shifted[15:0]};
    endfunction

    task automatic check_val(input string what, input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, expv, actv);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // Inputs change 1 ns after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
        cfg_cmd      = CFG_NOP;
    endtask

    task automatic send_sample(input logic [15:0] s);
        logic [16:0] r;
        next_cycle();
        sample_valid = 1'b1;
        sample_in    = s;
        r = ref_filter(s);
        exp_q.push_back('{cyc: cyc, sat: r[16], data: r[15:0]});
    endtask

    task automatic cfg_write(input logic [5:0] addr, input logic [15:0] data);
        next_cycle();
        cfg_cmd  = CFG_WRITE;
        cfg_addr = addr;
        cfg_data = data;
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (addr == 6'(i)) begin
                ref_coef[i] = data;  // Out-of-range addresses touch nothing.
            end
        end
    endtask

    task automatic cfg_clear();
        next_cycle();
        cfg_cmd = CFG_CLEAR;
        for (int i = 0; i < NUM_TAPS; i++) begin
            ref_coef[i] = '0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    task automatic check_idle_outputs();
        check_val("out_valid", 0, 32'(out_valid));
        check_val("out_sat", 0, 32'(out_sat));
        check_val("data_out", 0, 32'(data_out));
    endtask

    // Outputs are sampled on the falling edge.
    always @(negedge clk) begin
        exp_t e;
        if (rst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output at cycle %0d with no sample waiting for it", cyc);
                end else begin
                    e = exp_q.pop_front();
                    check_val("data", 32'(e.data), 32'(data_out));
                    check_val("sat", 32'(e.sat), 32'(out_sat));
                    check_val("latency", e.cyc + 4, cyc);
                    last_data = data_out;
                    last_sat  = out_sat;
                end
            end else if (exp_q.size() > 0 && cyc >= exp_q[0].cyc + 4) begin
                errors++;
                $display("No output for the sample sent in cycle %0d", exp_q[0].cyc);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (cyc >= MAX_CYCLES) begin
            errors++;
            $display("Timeout after %0d cycles, the DUT stopped producing outputs", cyc);
            finish_run();
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_in    = '0;
        cfg_cmd      = CFG_NOP;
        cfg_addr     = '0;
        cfg_data     = '0;
        last_data    = '0;
        last_sat     = 1'b0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            ref_hist[i] = '0;
            ref_coef[i] = '0;
        end

        repeat (10) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        rst_n = 1'b1;
        test_name = "after_reset";
        repeat (4) begin
            next_cycle();
            check_idle_outputs();
        end

        test_name = "impulse";
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_write(6'(k), 16'(k + 1));
        end
        send_sample(16'hFFFF);
        repeat (NUM_TAPS + 7) send_sample(16'h0000);
        wait_drain();

        test_name = "random";
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_write(6'(k), rand_bits(16));
        end
        repeat (200) send_sample(rand_bits(16));
        wait_drain();

        test_name = "saturation";
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_write(6'(k), 16'hFFFF);
        end
        repeat (NUM_TAPS + 8) send_sample(16'hFFFF);
        wait_drain();
        check_val("full_data", 65535, 32'(last_data));
        check_val("full_sat", 1, 32'(last_sat));

        test_name = "clear";
        cfg_clear();
        repeat (40) send_sample(rand_bits(16));
        wait_drain();
        check_val("cleared_data", 0, 32'(last_data));

        test_name = "rewrite";
        cfg_write(6'd5, 16'd1000);
        cfg_write(6'(NUM_TAPS + 8), 16'd1234);  // Beyond the last tap.
        repeat (40) send_sample(rand_bits(16));
        wait_drain();

        test_name = "gaps";
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_write(6'(k), rand_bits(16));
        end
        repeat (100) begin
            repeat (rand_bits(2)) begin
                next_cycle();
                sample_in = rand_bits(16);  // Junk without a strobe.
            end
            send_sample(rand_bits(16));
        end
        wait_drain();

        finish_run();
    end

endmodule

`default_nettype wire

/* files.f */
fir_dsp_pkg.sv
fir_cfg_pkg.sv
fir_coeff_bank.sv
fir_delay_line.sv
fir_mac_tree.sv
fir_top.sv
tb_fir_top.sv

/* Makefile */
# Verilator build and run for the FIR filter testbench.

VERILATOR ?= verilator
TOP       ?= tb_fir_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
